// File: logic/cache_pkg.sv
package cache_pkg;

    localparam int ADDR_W     = 15;
    localparam int TAG_W      = 8;
    localparam int INDEX_W    = 2;
    localparam int WAYS       = 4;
    localparam int LINE_BYTES = 16;

    typedef logic [LINE_BYTES*8-1:0] line_t;
    typedef logic [LINE_BYTES-1:0]   mask_t;
    typedef logic [1:0]              way_t;
    typedef logic [1:0]              age_t;

    // Tag 14:7, index 6:5, bank 4, offset 3:0
    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
        logic               bank;
        logic [3:0]         offset;
    } addr_fields_t;

    typedef union packed {
        logic [ADDR_W-1:0] raw;
        addr_fields_t      f;
    } phys_addr_u;

endpackage

// File: logic/refill_if.sv
interface refill_if
    import cache_pkg::*;
();

    logic               install;
    logic [INDEX_W-1:0] index;
    way_t               way;
    logic [TAG_W-1:0]   tag;
    line_t              line;

    modport ctrl (
        output install, index, way, tag, line
    );

    // All three stores take the install on the same edge
    modport store (
        input install, index, way, tag, line
    );

endinterface

// File: logic/tag_store.sv
module tag_store
    import cache_pkg::*;
#(
    parameter int SETS = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [INDEX_W-1:0]            index,
    input  logic [TAG_W-1:0]              tag,
    refill_if.store                       refill,
    output logic [WAYS-1:0][TAG_W-1:0]    tags,
    output logic [WAYS-1:0]               valid
);

    localparam int SET_W = $clog2(SETS);

    logic [WAYS-1:0][TAG_W-1:0] tag_q [SETS];
    logic [WAYS-1:0]            valid_q [SETS];

    always_ff @(posedge clk) begin
        if (refill.install) begin
            tag_q[refill.index[SET_W-1:0]][refill.way] <= refill.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else if (refill.install) begin
            valid_q[refill.index[SET_W-1:0]][refill.way] <= 1'b1;
        end
    end

    // All ways of the set go out for compare
    assign tags  = tag_q[index[SET_W-1:0]];
    assign valid = valid_q[index[SET_W-1:0]];

    // Requester holds its address, so the fill lands where it is waiting
    a_install_matches_req: assert property (@(posedge clk) disable iff (!rst_n)
        refill.install |-> (refill.tag == tag) && (refill.index == index));

endmodule

// File: logic/data_store.sv
module data_store
    import cache_pkg::*;
#(
    parameter int SETS = 4
) (
    input  logic               clk,
    input  logic [INDEX_W-1:0] index,
    input  way_t               hit_way,
    input  logic               write_en,
    input  line_t              wdata,
    input  mask_t              wmask,
    refill_if.store            refill,
    output line_t              line,
    input  way_t               victim,
    output line_t              victim_line
);

    localparam int SET_W = $clog2(SETS);

    line_t mem_q [SETS][WAYS];
    line_t merged;

    // Byte merge against the current hit line
    always_comb begin
        merged = line;
        for (int b = 0; b < LINE_BYTES; b++) begin
            if (wmask[b]) begin
                merged[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write_en) begin
            mem_q[index[SET_W-1:0]][hit_way] <= merged;
        end else if (refill.install) begin
            mem_q[refill.index[SET_W-1:0]][refill.way] <= refill.line;
        end
    end

    assign line        = mem_q[index[SET_W-1:0]][hit_way];
    assign victim_line = mem_q[index[SET_W-1:0]][victim];

    a_no_write_during_install: assert property (@(posedge clk)
        !(write_en && refill.install));

endmodule

// File: logic/meta_store.sv
module meta_store
    import cache_pkg::*;
#(
    parameter int SETS = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [INDEX_W-1:0] index,
    input  logic               access_en,
    input  way_t               access_way,
    input  logic               set_dirty,
    refill_if.store            refill,
    output logic [WAYS-1:0]    dirty,
    output age_t [WAYS-1:0]    ages
);

    localparam int SET_W = $clog2(SETS);

    logic [WAYS-1:0] dirty_q [SETS];
    age_t [WAYS-1:0] age_q [SETS];

    logic             touch;
    logic [SET_W-1:0] t_set;
    way_t             t_way;
    age_t             t_age;
    age_t [WAYS-1:0]  new_ages;

    function automatic logic is_perm(input age_t [WAYS-1:0] a);
        logic [WAYS-1:0] seen;
        seen = '0;
        for (int i = 0; i < WAYS; i++) begin
            seen[a[i]] = 1'b1;
        end
        return &seen;
    endfunction

    // Install and access never overlap, install takes the mux when present
    assign touch = access_en | refill.install;
    assign t_set = refill.install ? refill.index[SET_W-1:0] : index[SET_W-1:0];
    assign t_way = refill.install ? refill.way : access_way;
    assign t_age = age_q[t_set][t_way];

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            if (way_t'(w) == t_way) begin
                new_ages[w] = '0;
            end else if (age_q[t_set][w] < t_age) begin
                new_ages[w] = age_q[t_set][w] + age_t'(1);
            end else begin
                new_ages[w] = age_q[t_set][w];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < SETS; s++) begin
                dirty_q[s] <= '0;
                for (int w = 0; w < WAYS; w++) begin
                    age_q[s][w] <= age_t'(w);
                end
            end
        end else if (touch) begin
            age_q[t_set] <= new_ages;
            if (refill.install) begin
                dirty_q[t_set][t_way] <= 1'b0;
            end else if (set_dirty) begin
                dirty_q[t_set][t_way] <= 1'b1;
            end
        end
    end

    assign dirty = dirty_q[index[SET_W-1:0]];
    assign ages  = age_q[index[SET_W-1:0]];

    a_ages_perm: assert property (@(posedge clk) disable iff (!rst_n) is_perm(ages));

endmodule

// File: logic/way_select.sv
module way_select
    import cache_pkg::*;
(
    input  logic [WAYS-1:0][TAG_W-1:0] tags,
    input  logic [WAYS-1:0]            valid,
    input  age_t [WAYS-1:0]            ages,
    input  logic [WAYS-1:0]            dirty,
    input  logic [TAG_W-1:0]           req_tag,
    output logic                       hit,
    output way_t                       hit_way,
    output way_t                       victim_way,
    output logic                       victim_dirty,
    output logic [TAG_W-1:0]           victim_tag
);

    logic [WAYS-1:0] match;
    logic            found_invalid;

    always_comb begin
        hit_way       = '0;
        victim_way    = '0;
        found_invalid = 1'b0;
        for (int w = 0; w < WAYS; w++) begin
            match[w] = valid[w] && (tags[w] == req_tag);
        end
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (match[w]) begin
                hit_way = way_t'(w);
            end
        end
        // Lowest invalid way first, else the oldest
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!valid[w]) begin
                victim_way    = way_t'(w);
                found_invalid = 1'b1;
            end
        end
        if (!found_invalid) begin
            for (int w = 0; w < WAYS; w++) begin
                if (ages[w] == age_t'(WAYS - 1)) begin
                    victim_way = way_t'(w);
                end
            end
        end
    end

    assign hit          = |match;
    assign victim_dirty = valid[victim_way] && dirty[victim_way];
    assign victim_tag   = tags[victim_way];

    always_comb begin
        a_single_match: assert final ($onehot0(match));
    end

endmodule

// File: logic/miss_ctrl.sv
module miss_ctrl
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic [ADDR_W-1:0] req_addr,
    input  way_t              victim_way,
    input  logic              victim_dirty,
    input  logic [TAG_W-1:0]  victim_tag,
    input  line_t             victim_line,
    output logic              idle,
    output logic              mem_req_valid,
    output logic              mem_req_write,
    output logic [ADDR_W-1:0] mem_req_addr,
    output line_t             mem_req_data,
    input  logic              mem_req_ready,
    input  logic              fill_valid,
    input  line_t             fill_data,
    refill_if.ctrl            refill
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WB,
        ST_FILL_REQ,
        ST_FILL_WAIT,
        ST_INSTALL
    } state_t;

    state_t           state;
    phys_addr_u       addr_q;
    phys_addr_u       line_addr;
    way_t             way_q;
    logic [TAG_W-1:0] vtag_q;
    line_t            vline_q;
    line_t            fill_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:      if (start) state <= victim_dirty ? ST_WB : ST_FILL_REQ;
                ST_WB:        if (mem_req_ready) state <= ST_FILL_REQ;
                ST_FILL_REQ:  if (mem_req_ready) state <= ST_FILL_WAIT;
                ST_FILL_WAIT: if (fill_valid) state <= ST_INSTALL;
                default:      state <= ST_IDLE;
            endcase
        end
    end

    // Miss context
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) begin
            addr_q.raw <= req_addr;
            way_q      <= victim_way;
            vtag_q     <= victim_tag;
            vline_q    <= victim_line;
        end
        if (state == ST_FILL_WAIT && fill_valid) begin
            fill_q <= fill_data;
        end
    end

    always_comb begin
        line_addr          = addr_q;
        line_addr.f.offset = '0;
        if (state == ST_WB) begin
            line_addr.f.tag = vtag_q;
        end
    end

    assign idle          = (state == ST_IDLE);
    assign mem_req_valid = (state == ST_WB) || (state == ST_FILL_REQ);
    assign mem_req_write = (state == ST_WB);
    assign mem_req_addr  = line_addr.raw;
    assign mem_req_data  = vline_q;

    assign refill.install = (state == ST_INSTALL);
    assign refill.index   = addr_q.f.index;
    assign refill.way     = way_q;
    assign refill.tag     = addr_q.f.tag;
    assign refill.line    = fill_q;

    a_mem_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && !mem_req_ready |=>
            mem_req_valid && $stable(mem_req_write) && $stable(mem_req_addr)
            && $stable(mem_req_data));

endmodule

// File: logic/cache_bank.sv
module cache_bank
    import cache_pkg::*;
#(
    parameter int SETS = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    input  logic              req_write,
    input  logic [ADDR_W-1:0] req_addr,
    input  line_t             req_data,
    input  mask_t             req_mask,
    output logic              req_ready,
    output logic              resp_valid,
    output line_t             resp_data,
    output logic              mem_req_valid,
    output logic              mem_req_write,
    output logic [ADDR_W-1:0] mem_req_addr,
    output line_t             mem_req_data,
    input  logic              mem_req_ready,
    input  logic              fill_valid,
    input  line_t             fill_data
);

    phys_addr_u                 addr;
    logic [WAYS-1:0][TAG_W-1:0] tags;
    logic [WAYS-1:0]            valid;
    logic [WAYS-1:0]            dirty;
    age_t [WAYS-1:0]            ages;
    logic                       hit;
    way_t                       hit_way;
    way_t                       victim_way;
    logic                       victim_dirty;
    logic [TAG_W-1:0]           victim_tag;
    line_t                      hit_line;
    line_t                      victim_line;
    logic                       idle;
    logic                       accept;
    logic                       start;

    refill_if refill_bus ();

    assign addr.raw = req_addr;

    // A read accepted last cycle holds off the next one for a cycle
    assign accept    = req_valid && hit && idle && !resp_valid;
    assign start     = req_valid && !hit && idle;
    assign req_ready = accept;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= accept && !req_write;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !req_write) begin
            resp_data <= hit_line;
        end
    end

    tag_store #(.SETS(SETS)) tag_store_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .index  (addr.f.index),
        .tag    (addr.f.tag),
        .refill (refill_bus.store),
        .tags   (tags),
        .valid  (valid)
    );

    data_store #(.SETS(SETS)) data_store_i (
        .clk         (clk),
        .index       (addr.f.index),
        .hit_way     (hit_way),
        .write_en    (accept && req_write),
        .wdata       (req_data),
        .wmask       (req_mask),
        .refill      (refill_bus.store),
        .line        (hit_line),
        .victim      (victim_way),
        .victim_line (victim_line)
    );

    meta_store #(.SETS(SETS)) meta_store_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .index      (addr.f.index),
        .access_en  (accept),
        .access_way (hit_way),
        .set_dirty  (req_write),
        .refill     (refill_bus.store),
        .dirty      (dirty),
        .ages       (ages)
    );

    way_select way_select_i (
        .tags         (tags),
        .valid        (valid),
        .ages         (ages),
        .dirty        (dirty),
        .req_tag      (addr.f.tag),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    miss_ctrl miss_ctrl_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .req_addr      (req_addr),
        .victim_way    (victim_way),
        .victim_dirty  (victim_dirty),
        .victim_tag    (victim_tag),
        .victim_line   (victim_line),
        .idle          (idle),
        .mem_req_valid (mem_req_valid),
        .mem_req_write (mem_req_write),
        .mem_req_addr  (mem_req_addr),
        .mem_req_data  (mem_req_data),
        .mem_req_ready (mem_req_ready),
        .fill_valid    (fill_valid),
        .fill_data     (fill_data),
        .refill        (refill_bus.ctrl)
    );

    a_resp_single: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |=> !resp_valid);

endmodule

// File: sim/cache_bank_tb.sv
module cache_bank_tb
    import cache_pkg::*;
();

    localparam int SETS      = 4;
    localparam int NUM_TESTS = 25;
    localparam int LIMIT     = NUM_TESTS * 40 + 100;

    typedef struct packed {
        logic              write;
        logic [ADDR_W-1:0] addr;
        line_t             data;
        mask_t             mask;
        int                xfers;
    } entry_t;

    typedef struct packed {
        logic              wr;
        logic [ADDR_W-1:0] addr;
        line_t             data;
    } xfer_t;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              req_valid;
    logic              req_write;
    logic [ADDR_W-1:0] req_addr;
    line_t             req_data;
    mask_t             req_mask;
    logic              req_ready;
    logic              resp_valid;
    line_t             resp_data;
    logic              mem_req_valid;
    logic              mem_req_write;
    logic [ADDR_W-1:0] mem_req_addr;
    line_t             mem_req_data;
    logic              mem_req_ready;
    logic              fill_valid;
    line_t             fill_data;
    logic              accepted_q = 1'b0;

    int     seed = 12;
    int     errors = 0;
    int     passed = 0;
    int     failed = 0;
    int     cycles = 0;
    int     n_entries = 0;
    entry_t stim [NUM_TESTS];
    xfer_t  act_q [$];
    xfer_t  exp_q [$];
    line_t  mem_lines [logic [ADDR_W-1:0]];
    line_t  model_mem [logic [ADDR_W-1:0]];

    // Reference cache state
    logic [TAG_W-1:0] m_tag [SETS][WAYS];
    logic             m_valid [SETS][WAYS];
    logic             m_dirty [SETS][WAYS];
    age_t             m_age [SETS][WAYS];
    line_t            m_data [SETS][WAYS];

    cache_bank #(.SETS(SETS)) dut_i (.*);

    always #50 clk = ~clk;

    // Marks the edge that took the request
    always @(posedge clk) accepted_q <= req_valid && req_ready;

    function automatic line_t pattern_line(input logic [ADDR_W-1:0] la);
        line_t             l;
        logic [ADDR_W-1:0] a;
        for (int b = 0; b < LINE_BYTES; b++) begin
            a = la + ADDR_W'(b);
            l[b*8 +: 8] = a[7:0] ^ {a[14:8], 1'b1};
        end
        return l;
    endfunction

    function automatic line_t mem_read(input logic [ADDR_W-1:0] la);
        return mem_lines.exists(la) ? mem_lines[la] : pattern_line(la);
    endfunction

    task automatic check_value(input string what, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            passed++;
            $display("%s: pass", name);
        end else begin
            failed++;
            $display("%s: fail with %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic add_entry(input logic wr, input logic [TAG_W-1:0] tag, input int idx,
                             input mask_t mask, input logic [31:0] word, input int xfers);
        phys_addr_u a;
        a.f.tag    = tag;
        a.f.index  = idx[INDEX_W-1:0];
        a.f.bank   = 1'b0;
        a.f.offset = 4'(n_entries);
        stim[n_entries] = '{wr, a.raw, {4{word}}, mask, xfers};
        n_entries++;
    endtask

    task automatic load_table();
        // Set 1 cold fill, merge, then four lines and a re-read to steer the victim
        add_entry(1'b0, 8'h11, 1, 16'h0000, 32'h0, 1);
        add_entry(1'b1, 8'h11, 1, 16'h00F0, 32'hDEADBEEF, 0);
        add_entry(1'b0, 8'h11, 1, 16'h0000, 32'h0, 0);
        add_entry(1'b0, 8'h22, 1, 16'h0000, 32'h0, 1);
        add_entry(1'b0, 8'h33, 1, 16'h0000, 32'h0, 1);
        add_entry(1'b0, 8'h44, 1, 16'h0000, 32'h0, 1);
        add_entry(1'b0, 8'h11, 1, 16'h0000, 32'h0, 0);
        add_entry(1'b0, 8'h55, 1, 16'h0000, 32'h0, 1);
        add_entry(1'b0, 8'h22, 1, 16'h0000, 32'h0, 1);
        add_entry(1'b0, 8'h66, 1, 16'h0000, 32'h0, 1);
        // Dirty 8'h11 goes out, then comes back from memory
        add_entry(1'b0, 8'h77, 1, 16'h0000, 32'h0, 2);
        add_entry(1'b0, 8'h11, 1, 16'h0000, 32'h0, 1);
        add_entry(1'b1, 8'h05, 2, 16'hFFFF, 32'h12345678, 1);
        add_entry(1'b1, 8'h06, 2, 16'h000F, 32'hCAFEF00D, 1);
        add_entry(1'b0, 8'h05, 2, 16'h0000, 32'h0, 0);
        add_entry(1'b0, 8'h05, 0, 16'h0000, 32'h0, 1);
        add_entry(1'b1, 8'h05, 0, 16'h8000, 32'hA5A5A5A5, 0);
        add_entry(1'b1, 8'h07, 2, 16'h0FF0, 32'h0BADC0DE, 1);
        add_entry(1'b1, 8'h08, 2, 16'hF00F, 32'h600DD00D, 1);
        // Set 2 is all dirty now
        add_entry(1'b0, 8'h09, 2, 16'h0000, 32'h0, 2);
        add_entry(1'b0, 8'h06, 2, 16'h0000, 32'h0, 2);
        add_entry(1'b0, 8'h05, 2, 16'h0000, 32'h0, 2);
        add_entry(1'b0, 8'h05, 0, 16'h0000, 32'h0, 0);
        add_entry(1'b1, 8'h7F, 3, 16'h0F0F, 32'h13579BDF, 1);
        add_entry(1'b0, 8'h7F, 3, 16'h0000, 32'h0, 0);
    endtask

    task automatic clear_model();
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_age[s][w]   = age_t'(w);
            end
        end
    endtask

    task automatic touch_way(input int s, input int w);
        age_t t;
        t = m_age[s][w];
        for (int i = 0; i < WAYS; i++) begin
            if (m_age[s][i] < t) m_age[s][i] = m_age[s][i] + age_t'(1);
        end
        m_age[s][w] = '0;
    endtask

    task automatic predict_access(input entry_t e, output line_t resp);
        phys_addr_u a;
        phys_addr_u v;
        phys_addr_u la;
        xfer_t      x;
        int         s;
        int         w;
        a.raw = e.addr;
        s     = int'(a.f.index);
        w     = -1;
        for (int i = WAYS - 1; i >= 0; i--) begin
            if (m_valid[s][i] && m_tag[s][i] == a.f.tag) w = i;
        end
        if (w < 0) begin
            for (int i = WAYS - 1; i >= 0; i--) begin
                if (!m_valid[s][i]) w = i;
            end
            if (w < 0) begin
                for (int i = 0; i < WAYS; i++) begin
                    if (m_age[s][i] == age_t'(3)) w = i;
                end
            end
            la          = a;
            la.f.offset = '0;
            if (m_valid[s][w] && m_dirty[s][w]) begin
                v                = la;
                v.f.tag          = m_tag[s][w];
                model_mem[v.raw] = m_data[s][w];
                x                = '{1'b1, v.raw, m_data[s][w]};
                exp_q.push_back(x);
            end
            x = '{1'b0, la.raw, '0};
            exp_q.push_back(x);
            m_data[s][w]  = model_mem.exists(la.raw) ? model_mem[la.raw] : pattern_line(la.raw);
            m_tag[s][w]   = a.f.tag;
            m_valid[s][w] = 1'b1;
            m_dirty[s][w] = 1'b0;
            touch_way(s, w);
        end
        touch_way(s, w);
        if (e.write) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (e.mask[b]) m_data[s][w][b*8 +: 8] = e.data[b*8 +: 8];
            end
            m_dirty[s][w] = 1'b1;
        end
        resp = m_data[s][w];
    endtask

    // Memory with random ready stalls and fill delays
    initial begin
        xfer_t             x;
        int                stall;
        int                fill_cnt;
        logic              armed;
        logic              fill_pending;
        logic [ADDR_W-1:0] fill_addr;
        mem_req_ready = 1'b0;
        fill_valid    = 1'b0;
        fill_data     = '0;
        stall         = 0;
        fill_cnt      = 0;
        armed         = 1'b0;
        fill_pending  = 1'b0;
        fill_addr     = '0;
        forever begin
            @(negedge clk);
            mem_req_ready = 1'b0;
            fill_valid    = 1'b0;
            if (fill_pending) begin
                if (fill_cnt == 0) begin
                    fill_valid   = 1'b1;
                    fill_data    = mem_read(fill_addr);
                    fill_pending = 1'b0;
                end else begin
                    fill_cnt--;
                end
            end
            if (rst_n && mem_req_valid) begin
                if (!armed) begin
                    stall = $random(seed) & 7;
                    armed = 1'b1;
                end
                if (stall == 0) begin
                    // Handshake completes on the next rising edge
                    mem_req_ready = 1'b1;
                    armed         = 1'b0;
                    x             = '{mem_req_write, mem_req_addr, mem_req_data};
                    act_q.push_back(x);
                    if (mem_req_write) begin
                        mem_lines[mem_req_addr] = mem_req_data;
                    end else begin
                        fill_pending = 1'b1;
                        fill_addr    = mem_req_addr;
                        fill_cnt     = $random(seed) & 7;
                    end
                end else begin
                    stall--;
                end
            end
        end
    end

    initial begin
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", LIMIT);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        entry_t e;
        line_t  exp_line;
        int     errs_before;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_data  = '0;
        req_mask  = '0;
        load_table();
        clear_model();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        errs_before = errors;
        repeat (2) begin
            @(negedge clk);
            check_value("req_ready after reset", 128'(req_ready), 128'(0));
            check_value("resp_valid after reset", 128'(resp_valid), 128'(0));
            check_value("mem_req_valid after reset", 128'(mem_req_valid), 128'(0));
        end
        report_test("reset state", errs_before);

        for (int i = 0; i < NUM_TESTS; i++) begin
            e           = stim[i];
            errs_before = errors;
            predict_access(e, exp_line);
            req_valid = 1'b1;
            req_write = e.write;
            req_addr  = e.addr;
            req_data  = e.data;
            req_mask  = e.mask;
            do begin
                @(negedge clk);
            end while (!accepted_q);
            req_valid = 1'b0;
            if (e.write) begin
                check_value("resp_valid after write", 128'(resp_valid), 128'(0));
            end else begin
                check_value("resp_valid after read", 128'(resp_valid), 128'(1));
                check_value("resp_data", resp_data, exp_line);
            end
            check_value("transfer count", 128'(act_q.size()), 128'(e.xfers));
            check_value("predicted transfer count", 128'(exp_q.size()), 128'(e.xfers));
            for (int k = 0; k < exp_q.size() && k < act_q.size(); k++) begin
                check_value("transfer kind", 128'(act_q[k].wr), 128'(exp_q[k].wr));
                check_value("transfer address", 128'(act_q[k].addr), 128'(exp_q[k].addr));
                if (exp_q[k].wr) check_value("write-back data", act_q[k].data, exp_q[k].data);
            end
            act_q.delete();
            exp_q.delete();
            report_test($sformatf("test %0d %s %h", i, e.write ? "write" : "read", e.addr),
                        errs_before);
        end

        $display("%0d tests, %0d passed, %0d failed, %0d check errors",
                 passed + failed, passed, failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
logic/cache_pkg.sv
logic/refill_if.sv
logic/tag_store.sv
logic/data_store.sv
logic/meta_store.sv
logic/way_select.sv
logic/miss_ctrl.sv
logic/cache_bank.sv
sim/cache_bank_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cache_bank_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
